//--- common/overlayPkg.sv
package overlayPkg;

   // ================================================
   // Digit and control types
   // ================================================
   typedef logic [3:0] bcdDigit;  // 0 to 9

   typedef struct packed {
      bcdDigit hoursTens;
      bcdDigit hoursUnits;
      bcdDigit minutesTens;
      bcdDigit minutesUnits;
      bcdDigit secondsTens;
      bcdDigit secondsUnits;
   } clockDigits;

   typedef struct packed {
      bcdDigit dayTens;
      bcdDigit dayUnits;
      bcdDigit monthTens;
      bcdDigit monthUnits;
   } dateDigits;

   typedef enum logic [2:0] {
      none,
      hours,
      minutes,
      seconds,
      day,
      month
   } editField;

   typedef enum logic [1:0] {
      flatColor,
      bigDigit,
      smallDigit
   } glyphKind;

   typedef logic [2:0] colorIndex;

   localparam colorIndex colorGreen = 3'd0;
   localparam colorIndex colorBlack = 3'd1;
   localparam colorIndex colorWhite = 3'd2;
   localparam colorIndex colorPanel = 3'd3;
   localparam colorIndex colorEdge  = 3'd5;  // Thin frame lines of the panel

   // Stage one result, coordinates already folded into the field
   typedef struct packed {
      logic       hit;
      glyphKind   kind;
      bcdDigit    digit;
      logic [6:0] glyphRow;
      logic [5:0] glyphCol;
      colorIndex  color;
   } classifiedPixel;

   typedef struct packed {
      logic [15:0] pad;
      colorIndex   color;
   } paddedColor;

   // graphicsSel tells which view is live
   typedef union packed {
      logic [18:0] romAddr;
      paddedColor  flat;
   } pixelSource;

   typedef struct packed {
      logic       pixelValid;
      logic       graphicsSel;
      pixelSource source;
   } overlayPixel;

   // ================================================
   // Screen geometry
   // ================================================
   localparam logic [9:0] dividerTop    = 10'd244;
   localparam logic [9:0] dividerBottom = 10'd247;

   localparam logic [9:0] bigTop           = 10'd197;
   localparam logic [9:0] bigWidth         = 10'd62;
   localparam logic [9:0] bigHeight        = 10'd105;
   localparam logic [9:0] hoursTensLeft    = 10'd59;
   localparam logic [9:0] hoursUnitsLeft   = 10'd123;
   localparam logic [9:0] minutesTensLeft  = 10'd260;
   localparam logic [9:0] minutesUnitsLeft = 10'd324;
   localparam logic [9:0] secondsTensLeft  = 10'd459;
   localparam logic [9:0] secondsUnitsLeft = 10'd524;
   localparam logic [9:0] bigFontBaseRow   = 10'd5;

   localparam logic [9:0] smallTop         = 10'd454;
   localparam logic [9:0] smallWidth       = 10'd8;
   localparam logic [9:0] smallHeight      = 10'd12;
   localparam logic [9:0] dayTensLeft      = 10'd463;
   localparam logic [9:0] dayUnitsLeft     = 10'd470;
   localparam logic [9:0] monthTensLeft    = 10'd495;
   localparam logic [9:0] monthUnitsLeft   = 10'd502;
   localparam logic [9:0] smallFontBaseRow = 10'd326;

   // Underlines, rows counted from the glyph bottom
   localparam logic [9:0] bigCursorWidth   = 10'd218;
   localparam logic [9:0] bigCursorFirst   = 10'd4;
   localparam logic [9:0] bigCursorLast    = 10'd6;
   localparam logic [9:0] smallCursorWidth = 10'd16;
   localparam logic [9:0] smallCursorFirst = 10'd2;
   localparam logic [9:0] smallCursorLast  = 10'd3;

   // ================================================
   // Glyph memory column of each digit
   // ================================================
   localparam logic [9:0] bigDigitOffset [10] = '{
      10'd0, 10'd67, 10'd127, 10'd192, 10'd253,
      10'd320, 10'd383, 10'd450, 10'd511, 10'd576
   };

   localparam logic [9:0] smallDigitOffset [10] = '{
      10'd1, 10'd10, 10'd21, 10'd31, 10'd40,
      10'd51, 10'd60, 10'd71, 10'd80, 10'd90
   };

endpackage

//--- layout/backgroundPainter.sv
`timescale 1ns/10ps

module backgroundPainter (
   input  logic [9:0]            pixelX,
   input  logic [9:0]            pixelY,
   output logic                  bandValid,
   output overlayPkg::colorIndex bandColor
);

   logic inPanelRows;
   overlayPkg::colorIndex panelColor;

   assign inPanelRows = (pixelY >= 10'd158) && (pixelY <= 10'd264);

   // ================================================
   // Column stripes behind the large digits
   // ================================================
   always_comb begin
      if (pixelX <= 10'd28) begin
         panelColor = overlayPkg::colorBlack;
      end else if (pixelX == 10'd29) begin
         panelColor = overlayPkg::colorEdge;
      end else if (pixelX <= 10'd212) begin
         panelColor = overlayPkg::colorPanel;   // Hours panel
      end else if (pixelX == 10'd213) begin
         panelColor = overlayPkg::colorEdge;
      end else if (pixelX <= 10'd228) begin
         panelColor = overlayPkg::colorBlack;
      end else if (pixelX == 10'd229) begin
         panelColor = overlayPkg::colorEdge;
      end else if (pixelX <= 10'd412) begin
         panelColor = overlayPkg::colorPanel;   // Minutes panel
      end else if (pixelX == 10'd413) begin
         panelColor = overlayPkg::colorEdge;
      end else if (pixelX <= 10'd428) begin
         panelColor = overlayPkg::colorBlack;
      end else if (pixelX == 10'd429) begin
         panelColor = overlayPkg::colorEdge;
      end else if (pixelX <= 10'd612) begin
         panelColor = overlayPkg::colorPanel;   // Seconds panel
      end else if (pixelX == 10'd613) begin
         panelColor = overlayPkg::colorEdge;
      end else begin
         panelColor = overlayPkg::colorBlack;
      end
   end

   // ================================================
   // Horizontal bands, top to bottom
   // ================================================
   always_comb begin
      bandValid = 1'b1;
      bandColor = overlayPkg::colorGreen;
      if (pixelY <= 10'd140) begin
         bandColor = overlayPkg::colorGreen;
      end else if (inPanelRows) begin
         bandColor = panelColor;
      end else if ((pixelY >= 10'd349) && (pixelY <= 10'd351)) begin
         bandColor = overlayPkg::colorGreen;
      end else if ((pixelY >= 10'd352) && (pixelY <= 10'd353)) begin
         bandColor = overlayPkg::colorBlack;     // Thin line under the panel
      end else if ((pixelY >= 10'd354) && (pixelY <= 10'd472)) begin
         bandColor = overlayPkg::colorGreen;
      end else if ((pixelY >= 10'd473) && (pixelY <= 10'd480)) begin
         bandColor = overlayPkg::colorWhite;
      end else begin
         bandValid = 1'b0;  // Gaps and off screen
      end
   end

endmodule

//--- layout/fieldSelector.sv
`timescale 1ns/10ps

module fieldSelector (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [9:0]                 pixelX,
   input  logic [9:0]                 pixelY,
   input  overlayPkg::clockDigits     timeDigits,
   input  overlayPkg::dateDigits      date,
   input  logic                       editEnable,
   input  overlayPkg::editField       cursorField,
   output overlayPkg::classifiedPixel stageOne
);

   // Left edges in priority order
   localparam logic [9:0] bigLeft [6] = '{
      overlayPkg::secondsTensLeft, overlayPkg::secondsUnitsLeft,
      overlayPkg::minutesTensLeft, overlayPkg::minutesUnitsLeft,
      overlayPkg::hoursTensLeft, overlayPkg::hoursUnitsLeft
   };
   localparam logic [9:0] smallLeft [4] = '{
      overlayPkg::dayTensLeft, overlayPkg::dayUnitsLeft,
      overlayPkg::monthTensLeft, overlayPkg::monthUnitsLeft
   };

   logic                      bandValid;
   overlayPkg::colorIndex     bandColor;
   overlayPkg::bcdDigit       bigValue [6];
   overlayPkg::bcdDigit       smallValue [4];
   logic                      bigHit;
   logic                      smallHit;
   overlayPkg::bcdDigit       bigSel;
   overlayPkg::bcdDigit       smallSel;
   logic [9:0]                bigColFull;
   logic [9:0]                smallColFull;
   logic [9:0]                bigRowFull;
   logic [9:0]                smallRowFull;
   logic                      bigCursorArmed;
   logic                      smallCursorArmed;
   logic [9:0]                bigCursorLeft;
   logic [9:0]                smallCursorLeft;
   logic                      bigCursorOn;
   logic                      smallCursorOn;
   overlayPkg::classifiedPixel classified;

   function automatic logic inWindow(input logic [9:0] x, input logic [9:0] y,
                                     input logic [9:0] left, input logic [9:0] top,
                                     input logic [9:0] width, input logic [9:0] height);
      return (x >= left) && (x <= left + width) && (y >= top) && (y <= top + height);
   endfunction

   backgroundPainter painter (
      .pixelX   (pixelX),
      .pixelY   (pixelY),
      .bandValid(bandValid),
      .bandColor(bandColor)
   );

   assign bigValue = '{timeDigits.secondsTens, timeDigits.secondsUnits,
                       timeDigits.minutesTens, timeDigits.minutesUnits,
                       timeDigits.hoursTens, timeDigits.hoursUnits};
   assign smallValue = '{date.dayTens, date.dayUnits, date.monthTens, date.monthUnits};

   assign bigRowFull   = pixelY - overlayPkg::bigTop;
   assign smallRowFull = pixelY - overlayPkg::smallTop;

   // ================================================
   // Digit windows, first one found wins
   // ================================================
   always_comb begin
      bigHit       = 1'b0;
      bigSel       = '0;
      bigColFull   = '0;
      smallHit     = 1'b0;
      smallSel     = '0;
      smallColFull = '0;
      for (int i = 0; i < 6; i++) begin
         if (!bigHit && inWindow(pixelX, pixelY, bigLeft[i], overlayPkg::bigTop,
                                 overlayPkg::bigWidth, overlayPkg::bigHeight)) begin
            bigHit     = 1'b1;
            bigSel     = bigValue[i];
            bigColFull = pixelX - bigLeft[i];  // Column from this field's edge
         end
      end
      for (int i = 0; i < 4; i++) begin
         if (!smallHit && inWindow(pixelX, pixelY, smallLeft[i], overlayPkg::smallTop,
                                   overlayPkg::smallWidth, overlayPkg::smallHeight)) begin
            smallHit     = 1'b1;
            smallSel     = smallValue[i];
            smallColFull = pixelX - smallLeft[i];
         end
      end
   end

   // Cursor sits under the tens digit of the chosen field
   always_comb begin
      bigCursorArmed   = 1'b0;
      smallCursorArmed = 1'b0;
      bigCursorLeft    = overlayPkg::hoursTensLeft;
      smallCursorLeft  = overlayPkg::dayTensLeft;
      case (cursorField)
         overlayPkg::hours:   bigCursorArmed = editEnable;
         overlayPkg::minutes: begin
            bigCursorArmed = editEnable;
            bigCursorLeft  = overlayPkg::minutesTensLeft;
         end
         overlayPkg::seconds: begin
            bigCursorArmed = editEnable;
            bigCursorLeft  = overlayPkg::secondsTensLeft;
         end
         overlayPkg::day:     smallCursorArmed = editEnable;
         overlayPkg::month: begin
            smallCursorArmed = editEnable;
            smallCursorLeft  = overlayPkg::monthTensLeft;
         end
         default: ;  // No field selected
      endcase
   end

   assign bigCursorOn = bigCursorArmed
      && (pixelX >= bigCursorLeft) && (pixelX <= bigCursorLeft + overlayPkg::bigCursorWidth)
      && (pixelY >= overlayPkg::bigTop + overlayPkg::bigHeight + overlayPkg::bigCursorFirst)
      && (pixelY <= overlayPkg::bigTop + overlayPkg::bigHeight + overlayPkg::bigCursorLast);

   assign smallCursorOn = smallCursorArmed
      && (pixelX >= smallCursorLeft)
      && (pixelX <= smallCursorLeft + overlayPkg::smallCursorWidth)
      && (pixelY >= overlayPkg::smallTop + overlayPkg::smallHeight + overlayPkg::smallCursorFirst)
      && (pixelY <= overlayPkg::smallTop + overlayPkg::smallHeight + overlayPkg::smallCursorLast);

   // ================================================
   // Priority chain and stage register
   // ================================================
   always_comb begin
      classified      = '0;
      classified.kind = overlayPkg::flatColor;
      if ((pixelY >= overlayPkg::dividerTop) && (pixelY <= overlayPkg::dividerBottom)) begin
         classified.hit   = 1'b1;
         classified.color = overlayPkg::colorBlack;
      end else if (bigHit) begin
         classified.hit      = 1'b1;
         classified.kind     = overlayPkg::bigDigit;
         classified.digit    = bigSel;
         classified.glyphRow = bigRowFull[6:0];
         classified.glyphCol = bigColFull[5:0];
      end else if (bigCursorOn) begin
         classified.hit   = 1'b1;
         classified.color = overlayPkg::colorWhite;
      end else if (smallHit) begin
         classified.hit      = 1'b1;
         classified.kind     = overlayPkg::smallDigit;
         classified.digit    = smallSel;
         classified.glyphRow = smallRowFull[6:0];
         classified.glyphCol = smallColFull[5:0];
      end else if (smallCursorOn) begin
         classified.hit   = 1'b1;
         classified.color = overlayPkg::colorWhite;
      end else begin
         classified.hit   = bandValid;  // Background fallback
         classified.color = bandColor;
      end
   end

   always_ff @(posedge clk) begin
      stageOne <= classified;
      if (reset) begin
         stageOne.hit <= 1'b0;
      end
   end

endmodule

//--- sprite/glyphAddressGen.sv
`timescale 1ns/10ps

module glyphAddressGen #(
   parameter int lineStride = 640  // Row pitch of the glyph memory
) (
   input  logic                       clk,
   input  logic                       reset,
   input  overlayPkg::classifiedPixel stageOne,
   output overlayPkg::overlayPixel    pixelOut
);

   logic                    digitInRange;
   logic [9:0]              fontBase;
   logic [9:0]              digitOffset;
   logic [18:0]             rowIndex;
   logic [18:0]             romAddr;
   logic                    isSprite;
   overlayPkg::overlayPixel result;

   assign digitInRange = (stageOne.digit <= 4'd9);

   // ================================================
   // Font table lookup
   // ================================================
   always_comb begin
      fontBase    = overlayPkg::bigFontBaseRow;
      digitOffset = '0;
      case (stageOne.kind)
         overlayPkg::bigDigit: begin
            if (digitInRange) begin
               digitOffset = overlayPkg::bigDigitOffset[stageOne.digit];
            end
         end
         overlayPkg::smallDigit: begin
            fontBase = overlayPkg::smallFontBaseRow;
            if (digitInRange) begin
               digitOffset = overlayPkg::smallDigitOffset[stageOne.digit];
            end
         end
         default: ;  // Flat colours need no lookup
      endcase
   end

   assign rowIndex = 19'(fontBase) + 19'(stageOne.glyphRow);

   // Base row times pitch, then glyph column
   assign romAddr = rowIndex * 19'(lineStride) + 19'(digitOffset) + 19'(stageOne.glyphCol);

   assign isSprite = stageOne.hit && (stageOne.kind != overlayPkg::flatColor);

   // ================================================
   // Output word and register
   // ================================================
   always_comb begin
      result.pixelValid  = stageOne.hit;
      result.graphicsSel = isSprite;
      if (isSprite) begin
         result.source.romAddr = romAddr;
      end else begin
         result.source.flat.pad   = '0;
         result.source.flat.color = stageOne.color;
      end
   end

   always_ff @(posedge clk) begin
      pixelOut <= result;
      if (reset) begin
         pixelOut.pixelValid  <= 1'b0;
         pixelOut.graphicsSel <= 1'b0;
      end
   end

endmodule

//--- source/clockOverlayTop.sv
`timescale 1ns/10ps

module clockOverlayTop #(
   parameter int lineStride = 640
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [9:0]              pixelX,
   input  logic [9:0]              pixelY,
   input  overlayPkg::clockDigits  timeDigits,
   input  overlayPkg::dateDigits   date,
   input  logic                    editEnable,
   input  overlayPkg::editField    cursorField,
   output overlayPkg::overlayPixel pixelOut
);

   overlayPkg::classifiedPixel stageOne;  // Between the two pipeline stages

   // ================================================
   // Stage one, field classification
   // ================================================
   fieldSelector selector (
      .clk        (clk),
      .reset      (reset),
      .pixelX     (pixelX),
      .pixelY     (pixelY),
      .timeDigits (timeDigits),
      .date       (date),
      .editEnable (editEnable),
      .cursorField(cursorField),
      .stageOne   (stageOne)
   );

   // ================================================
   // Stage two, glyph address or colour
   // ================================================
   glyphAddressGen #(
      .lineStride(lineStride)
   ) addressGen (
      .clk     (clk),
      .reset   (reset),
      .stageOne(stageOne),
      .pixelOut(pixelOut)
   );

endmodule

//--- bench/overlayTb.sv
`timescale 1ns/10ps

module overlayTb;

   localparam int    clockPeriod  = 20;
   localparam int    resetCycles  = 3;
   localparam int    vectorFields = 17;
   localparam string stimulusPath = "bench/overlay_stimulus.txt";

   // Expected output kept until its pixel leaves the pipeline
   typedef struct packed {
      logic [15:0] index;
      logic        valid;
      logic        sel;
      logic [18:0] source;
   } expectedPixel;

   logic                    clk;
   logic                    reset;
   logic [9:0]              pixelX;
   logic [9:0]              pixelY;
   overlayPkg::clockDigits  timeDigits;
   overlayPkg::dateDigits   date;
   logic                    editEnable;
   overlayPkg::editField    cursorField;
   overlayPkg::overlayPixel pixelOut;

   expectedPixel pending [$];  // Never more than three entries
   int           vectorCount;
   logic         countKnown;
   int           errorCount;
   int           checkCount;

   clockOverlayTop #(
      .lineStride(640)
   ) dut_i (
      .clk        (clk),
      .reset      (reset),
      .pixelX     (pixelX),
      .pixelY     (pixelY),
      .timeDigits (timeDigits),
      .date       (date),
      .editEnable (editEnable),
      .cursorField(cursorField),
      .pixelOut   (pixelOut)
   );

   always #(clockPeriod / 2) clk = ~clk;

   // ================================================
   // Stimulus file helpers
   // ================================================
   function automatic logic isVectorLine(input string line);
      return (line.len() > 0) && (line.getc(0) != "#") && (line.getc(0) != "\n");
   endfunction

   task automatic countVectors(output int count);
      int    fd;
      string line;
      count = 0;
      fd = $fopen(stimulusPath, "r");
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            if (isVectorLine(line)) begin
               count++;
            end
         end
         $fclose(fd);
      end
   endtask

   // ================================================
   // Output checks
   // ================================================
   task automatic checkResetState(input string phase);
      checkCount++;
      if ((pixelOut.pixelValid !== 1'b0) || (pixelOut.graphicsSel !== 1'b0)) begin
         errorCount++;
         $display("FAIL %0t: %s, pixelValid %0b graphicsSel %0b, both should be 0",
                  $time, phase, pixelOut.pixelValid, pixelOut.graphicsSel);
      end
   endtask

   task automatic compareOutput(input expectedPixel expected);
      checkCount++;
      if (pixelOut.pixelValid !== expected.valid) begin
         errorCount++;
         $display("FAIL %0t: vector %0d pixelValid expected %0b got %0b",
                  $time, expected.index, expected.valid, pixelOut.pixelValid);
      end
      if (pixelOut.graphicsSel !== expected.sel) begin
         errorCount++;
         $display("FAIL %0t: vector %0d graphicsSel expected %0b got %0b",
                  $time, expected.index, expected.sel, pixelOut.graphicsSel);
      end
      // Source word only means something on a valid pixel
      if (expected.valid && (pixelOut.source !== expected.source)) begin
         errorCount++;
         $display("FAIL %0t: vector %0d source expected %0d got %0d",
                  $time, expected.index, expected.source, pixelOut.source);
      end
   endtask

   // ================================================
   // Main sequence
   // ================================================
   initial begin
      int           fd;
      int           fields;
      int           index;
      string        line;
      logic [9:0]   xIn;
      logic [9:0]   yIn;
      logic [3:0]   clockIn [6];
      logic [3:0]   dateIn [4];
      logic         editIn;
      logic [2:0]   fieldIn;
      logic         validIn;
      logic         selIn;
      logic [18:0]  sourceIn;
      expectedPixel expected;

      clk         = 1'b0;
      reset       = 1'b1;
      // Top left pixel of the hours tens digit
      pixelX      = 10'd59;
      pixelY      = 10'd197;
      timeDigits  = '0;
      date        = '0;
      editEnable  = 1'b0;
      cursorField = overlayPkg::none;
      errorCount  = 0;
      checkCount  = 0;
      countKnown  = 1'b0;

      countVectors(vectorCount);
      countKnown = 1'b1;  // Starts the watchdog
      fd = $fopen(stimulusPath, "r");

      if (fd == 0) begin
         errorCount++;
         $display("Could not open the stimulus file %s", stimulusPath);
      end else if (vectorCount == 0) begin
         errorCount++;
         $display("The stimulus file %s holds no vectors", stimulusPath);
      end else begin
         repeat (resetCycles) begin
            @(posedge clk);
            #2;
            checkResetState("during reset");
         end
         reset = 1'b0;
         @(posedge clk);
         #2;
         checkResetState("first cycle after reset");

         index = 0;
         while ($fgets(line, fd) != 0) begin
            if (isVectorLine(line)) begin
               fields = $sscanf(line,
                  "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                  xIn, yIn, clockIn[0], clockIn[1], clockIn[2], clockIn[3],
                  clockIn[4], clockIn[5], dateIn[0], dateIn[1], dateIn[2], dateIn[3],
                  editIn, fieldIn, validIn, selIn, sourceIn);
               if (fields != vectorFields) begin
                  errorCount++;
                  $display("Stimulus line for vector %0d could not be read", index);
               end else begin
                  pixelX                  = xIn;
                  pixelY                  = yIn;
                  timeDigits.hoursTens    = clockIn[0];
                  timeDigits.hoursUnits   = clockIn[1];
                  timeDigits.minutesTens  = clockIn[2];
                  timeDigits.minutesUnits = clockIn[3];
                  timeDigits.secondsTens  = clockIn[4];
                  timeDigits.secondsUnits = clockIn[5];
                  date.dayTens            = dateIn[0];
                  date.dayUnits           = dateIn[1];
                  date.monthTens          = dateIn[2];
                  date.monthUnits         = dateIn[3];
                  editEnable              = editIn;
                  cursorField             = overlayPkg::editField'(fieldIn);

                  expected.index  = 16'(index);
                  expected.valid  = validIn;
                  expected.sel    = selIn;
                  expected.source = sourceIn;
                  pending.push_back(expected);

                  // Front entry was driven two edges ago
                  if (pending.size() == 3) begin
                     compareOutput(pending.pop_front());
                  end
                  @(posedge clk);
                  #2;
               end
               index++;
            end
         end

         // Drain the two pixels still in flight
         while (pending.size() > 0) begin
            compareOutput(pending.pop_front());
            @(posedge clk);
            #2;
         end
      end

      if (fd != 0) begin
         $fclose(fd);
      end
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // ================================================
   // Watchdog
   // ================================================
   initial begin
      wait (countKnown);
      #((vectorCount + 10) * clockPeriod);
      $display("Timeout, the run did not end within %0d clock cycles", vectorCount + 10);
      $display("Checks failed");
      $finish;
   end

endmodule

//--- bench/overlay_stimulus.txt
# x y hoursT hoursU minT minU secT secU dayT dayU monT monU editEnable cursorField
# then expected pixelValid graphicsSel source, all decimal
59 197 1 2 3 4 5 6 2 8 0 9 0 0 1 1 3267
100 230 1 2 3 4 5 6 2 8 0 9 0 0 1 1 24428
185 302 1 2 3 4 5 6 2 8 0 9 0 0 1 1 70589
280 210 1 2 3 4 5 6 2 8 0 9 0 0 1 1 11732
350 260 1 2 3 4 5 6 2 8 0 9 0 0 1 1 43799
470 200 1 2 3 4 5 6 2 8 0 9 0 0 1 1 5451
560 290 1 2 3 4 5 6 2 8 0 9 0 0 1 1 63139
61 198 0 7 5 8 4 9 2 8 0 9 0 0 1 1 3842
130 240 0 7 5 8 4 9 2 8 0 9 0 0 1 1 31177
322 250 0 7 5 8 4 9 2 8 0 9 0 0 1 1 37502
324 280 0 7 5 8 4 9 2 8 0 9 0 0 1 1 56831
500 220 0 7 5 8 4 9 2 8 0 9 0 0 1 1 18214
586 302 0 7 5 8 4 9 2 8 0 9 0 0 1 1 71038
122 200 1 2 3 4 5 6 2 8 0 9 0 0 1 0 3
100 245 1 2 3 4 5 6 2 8 0 9 0 0 1 0 1
600 244 1 2 3 4 5 6 2 8 0 9 0 0 1 0 1
29 160 1 2 3 4 5 6 2 8 0 9 0 0 1 0 5
100 160 1 2 3 4 5 6 2 8 0 9 0 0 1 0 3
213 160 1 2 3 4 5 6 2 8 0 9 0 0 1 0 5
10 200 1 2 3 4 5 6 2 8 0 9 0 0 1 0 1
220 264 1 2 3 4 5 6 2 8 0 9 0 0 1 0 1
300 50 1 2 3 4 5 6 2 8 0 9 0 0 1 0 0
300 150 1 2 3 4 5 6 2 8 0 9 0 0 0 0 0
300 350 1 2 3 4 5 6 2 8 0 9 0 0 1 0 0
300 353 1 2 3 4 5 6 2 8 0 9 0 0 1 0 1
300 400 1 2 3 4 5 6 2 8 0 9 0 0 1 0 0
300 475 1 2 3 4 5 6 2 8 0 9 0 0 1 0 2
300 481 1 2 3 4 5 6 2 8 0 9 0 0 0 0 0
639 520 1 2 3 4 5 6 2 8 0 9 0 0 0 0 0
463 454 1 2 3 4 5 6 2 8 0 9 0 0 1 1 208661
475 460 1 2 3 4 5 6 2 8 0 9 0 0 1 1 212565
497 466 1 2 3 4 5 6 2 8 0 9 0 0 1 1 216323
510 458 1 2 3 4 5 6 2 8 0 9 0 0 1 1 211298
200 307 1 2 3 4 5 6 2 8 0 9 1 1 1 0 2
200 307 1 2 3 4 5 6 2 8 0 9 0 1 0 0 0
400 306 1 2 3 4 5 6 2 8 0 9 1 2 1 0 2
459 308 1 2 3 4 5 6 2 8 0 9 1 3 1 0 2
100 307 1 2 3 4 5 6 2 8 0 9 1 3 0 0 0
470 468 1 2 3 4 5 6 2 8 0 9 1 4 1 0 2
470 468 1 2 3 4 5 6 2 8 0 9 0 4 1 0 0
511 469 1 2 3 4 5 6 2 8 0 9 1 5 1 0 2
200 307 1 2 3 4 5 6 2 8 0 9 1 0 0 0 0

//--- filelist.f
common/overlayPkg.sv
layout/backgroundPainter.sv
layout/fieldSelector.sv
sprite/glyphAddressGen.sv
source/clockOverlayTop.sv
bench/overlayTb.sv

//--- Makefile
# Verilator build and run for the clock overlay testbench

VERILATOR ?= verilator
TOP       ?= overlayTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
